//--- hdl/beam_if.sv
// Raster position with its sync and area flags, passed from one pipeline stage to the next
`timescale 1ns/1ns

`include "video_defs.svh"

interface beam_if;

    logic [`COORD_WIDTH-1:0] x;
    logic [`COORD_WIDTH-1:0] y;
    // already at output polarity
    logic hsync;
    logic vsync;
    logic draw_area;
    // high while the raster runs
    logic valid;

    // producing stage
    modport src (
        output x, y, hsync, vsync, draw_area, valid
    );

    // consuming stage
    modport dst (
        input x, y, hsync, vsync, draw_area, valid
    );

endinterface

//--- hdl/beam_timing.sv
// Raster generator: waits for the start strobe, then scans positions and produces syncs
`timescale 1ns/1ns

`include "video_defs.svh"

module beam_timing (
    input  logic clock,
    input  logic reset,
    input  logic start,
    beam_if.src  beam,
    output logic settled
);
    import video_pkg::*;

    run_state_t state;

    logic [`COORD_WIDTH-1:0] x_cnt;
    logic [`COORD_WIDTH-1:0] y_cnt;
    logic line_end;
    logic frame_end;
    logic h_in_sync;
    logic v_in_sync;
    logic in_draw;

    logic       frame_done;
    logic [3:0] frame_count;

    //////////////////////////////////////////////////
    // start control
    //////////////////////////////////////////////////

    // start only matters while idle; nothing but reset stops the raster
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= STATE_IDLE;
        end else if (state == STATE_IDLE && start) begin
            state <= STATE_RUN;
        end
    end

    //////////////////////////////////////////////////
    // raster counters
    //////////////////////////////////////////////////

    assign line_end  = (x_cnt == `H_TOTAL - 1);
    assign frame_end = line_end && (y_cnt == `V_TOTAL - 1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (state == STATE_RUN) begin
            if (line_end) begin
                x_cnt <= '0;
                if (frame_end) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // sync windows and beam register
    //////////////////////////////////////////////////

    assign h_in_sync = (x_cnt >= `H_SYNC_START) && (x_cnt < `H_SYNC_START + `H_SYNC_WIDTH);
    assign v_in_sync = (y_cnt >= `V_SYNC_START) && (y_cnt < `V_SYNC_START + `V_SYNC_WIDTH);
    assign in_draw   = (x_cnt < `H_VISIBLE) && (y_cnt < `V_VISIBLE);

    // beam lags the counters by one clock, so (0,0) shows up the cycle after start
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beam.x         <= '0;
            beam.y         <= '0;
            beam.hsync     <= ~`SYNC_ACTIVE;
            beam.vsync     <= ~`SYNC_ACTIVE;
            beam.draw_area <= 1'b0;
            beam.valid     <= 1'b0;
        end else if (state == STATE_RUN) begin
            beam.x         <= x_cnt;
            beam.y         <= y_cnt;
            beam.hsync     <= h_in_sync ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
            beam.vsync     <= v_in_sync ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
            beam.draw_area <= in_draw;
            beam.valid     <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // frame counting
    //////////////////////////////////////////////////

    // frame_done marks the cycle the beam holds the last position of a frame
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_done  <= 1'b0;
            frame_count <= '0;
            settled     <= 1'b0;
        end else begin
            frame_done <= (state == STATE_RUN) && frame_end;
            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
            // sticky once enough frames went by
            settled <= settled || (frame_count == `SETTLE_FRAMES);
        end
    end

    // counters never leave the raster while running
    a_raster_bounds : assert property (
        @(posedge clock) disable iff (reset)
        (state == STATE_RUN) |-> (x_cnt < `H_TOTAL) && (y_cnt < `V_TOTAL)
    ) else $error("raster counter out of range x=%0d y=%0d", x_cnt, y_cnt);

endmodule

//--- hdl/frame_reader.sv
// Frame-buffer address stage: turns the beam into a read address and delays it to meet the RAM data
`timescale 1ns/1ns

`include "video_defs.svh"

module frame_reader (
    input  logic clock,
    input  logic reset,
    beam_if.dst  beam_in,
    beam_if.src  beam_out,
    output logic [`FB_ADDR_WIDTH-1:0] rdaddr
);

    logic [`COORD_WIDTH-1:0] line_idx;
    logic [`COORD_WIDTH-1:0] col_idx;
    logic [`COORD_WIDTH-1:0] word_addr;

    // two-deep beam chain, index 1 is the older entry
    logic [`COORD_WIDTH-1:0] x_q [0:1];
    logic [`COORD_WIDTH-1:0] y_q [0:1];
    logic [1:0] hsync_q;
    logic [1:0] vsync_q;
    logic [1:0] draw_q;
    logic [1:0] valid_q;

    // each stored word covers a pixel pair on a line pair
    always_comb begin
        line_idx  = `COORD_WIDTH'(beam_in.y / `LINE_REPEAT);
        col_idx   = `COORD_WIDTH'(beam_in.x / `PIXEL_REPEAT);
        word_addr = `COORD_WIDTH'(line_idx * `FB_LINE_WORDS) + col_idx;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rdaddr <= '0;
        end else if (beam_in.valid && beam_in.draw_area) begin
            rdaddr <= word_addr[`FB_ADDR_WIDTH-1:0];
        end else begin
            rdaddr <= '0;
        end
    end

    // control flags of the two positions in flight
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_q <= {2{~`SYNC_ACTIVE}};
            vsync_q <= {2{~`SYNC_ACTIVE}};
            draw_q  <= '0;
            valid_q <= '0;
        end else begin
            hsync_q <= {hsync_q[0], beam_in.hsync};
            vsync_q <= {vsync_q[0], beam_in.vsync};
            draw_q  <= {draw_q[0], beam_in.draw_area};
            valid_q <= {valid_q[0], beam_in.valid};
        end
    end

    always_ff @(posedge clock) begin
        x_q[0] <= beam_in.x;
        y_q[0] <= beam_in.y;
        x_q[1] <= x_q[0];
        y_q[1] <= y_q[0];
    end

    assign beam_out.x         = x_q[1];
    assign beam_out.y         = y_q[1];
    assign beam_out.hsync     = hsync_q[1];
    assign beam_out.vsync     = vsync_q[1];
    assign beam_out.draw_area = draw_q[1];
    assign beam_out.valid     = valid_q[1];

    // full word address must fit the buffer before it is cut to rdaddr width
    a_addr_in_buffer : assert property (
        @(posedge clock) disable iff (reset)
        (beam_in.valid && beam_in.draw_area) |-> (word_addr < `FB_WORDS)
    ) else $error("word address %0d beyond frame buffer", word_addr);

endmodule

//--- hdl/scanline_shader.sv
// Output stage: darkens alternate lines, blanks outside the draw area and registers the video
`timescale 1ns/1ns

`include "video_defs.svh"

module scanline_shader (
    input  logic clock,
    input  logic reset,
    beam_if.dst  beam,
    input  video_pkg::pixel_t         rddata,
    input  video_pkg::scanline_mode_t scanline_mode,
    input  logic [7:0]                scanline_intensity,
    output video_pkg::pixel_t         video_out,
    output logic hsync,
    output logic vsync,
    output logic draw_area
);
    import video_pkg::*;

    logic   visible;
    logic   darken;
    pixel_t shaded;

    // channel times gain over 256
    function automatic logic [7:0] scale_channel(input logic [7:0] value,
                                                 input logic [7:0] gain);
        logic [15:0] product;
        product = value * gain;
        return product[15:8];
    endfunction

    always_comb begin
        visible = beam.valid && beam.draw_area;
        darken  = ((scanline_mode == SCANLINE_EVEN) && !beam.y[0])
               || ((scanline_mode == SCANLINE_ODD) && beam.y[0]);
        shaded  = rddata;
        if (darken) begin
            shaded.red   = scale_channel(rddata.red, scanline_intensity);
            shaded.green = scale_channel(rddata.green, scanline_intensity);
            shaded.blue  = scale_channel(rddata.blue, scanline_intensity);
        end
    end

    //////////////////////////////////////////////////
    // registered outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            hsync     <= ~`SYNC_ACTIVE;
            vsync     <= ~`SYNC_ACTIVE;
            draw_area <= 1'b0;
        end else begin
            // black outside the visible window
            video_out <= visible ? shaded : '0;
            hsync     <= beam.hsync;
            vsync     <= beam.vsync;
            draw_area <= visible;
        end
    end

    // only the three defined modes may reach the shader
    a_mode_legal : assert property (
        @(posedge clock) disable iff (reset)
        scanline_mode inside {SCANLINE_OFF, SCANLINE_EVEN, SCANLINE_ODD}
    ) else $error("undefined scanline mode %0d", scanline_mode);

endmodule

//--- hdl/video_defs.svh
// Video mode timing and frame-buffer geometry, included by every RTL and testbench file that needs them
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

//////////////////////////////////////////////////
// horizontal timing, in clocks
//////////////////////////////////////////////////

`define H_TOTAL         40
`define H_VISIBLE       32
`define H_SYNC_START    34
`define H_SYNC_WIDTH    3

//////////////////////////////////////////////////
// vertical timing, in lines
//////////////////////////////////////////////////

`define V_TOTAL         24
`define V_VISIBLE       16
`define V_SYNC_START    19
`define V_SYNC_WIDTH    2

// sync pulses are active low
`define SYNC_ACTIVE     1'b0

//////////////////////////////////////////////////
// line-doubled frame buffer
//////////////////////////////////////////////////

// output clocks per stored pixel
`define PIXEL_REPEAT    2
// output lines per stored line
`define LINE_REPEAT     2

`define FB_LINE_WORDS   16
`define FB_WORDS        128
`define FB_ADDR_WIDTH   7

// raster counter width
`define COORD_WIDTH     12

// complete frames before the output is considered stable
`define SETTLE_FRAMES   15

`endif

//--- hdl/video_output_top.sv
// Top level of the video output stage; connects timing, buffer read and shading to the pins
`timescale 1ns/1ns

`include "video_defs.svh"

module video_output_top (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  video_pkg::scanline_mode_t scanline_mode,
    input  logic [7:0]                scanline_intensity,
    output logic [`FB_ADDR_WIDTH-1:0] rdaddr,
    input  logic [23:0] rddata,
    output logic [23:0] video_out,
    output logic hsync,
    output logic vsync,
    output logic draw_area,
    output logic settled
);

    // beam at the counters, and beam lined up with RAM data
    beam_if beam_t0 ();
    beam_if beam_t2 ();

    beam_timing u_beam_timing (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .beam    (beam_t0),
        .settled (settled)
    );

    frame_reader u_frame_reader (
        .clock    (clock),
        .reset    (reset),
        .beam_in  (beam_t0),
        .beam_out (beam_t2),
        .rdaddr   (rdaddr)
    );

    scanline_shader u_scanline_shader (
        .clock              (clock),
        .reset              (reset),
        .beam               (beam_t2),
        .rddata             (rddata),
        .scanline_mode      (scanline_mode),
        .scanline_intensity (scanline_intensity),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

endmodule

//--- hdl/video_pkg.sv
// Shared types for the video output stage, imported by the RTL modules that use them
package video_pkg;

    // raster run control
    typedef enum logic [0:0] {
        STATE_IDLE = 1'b0,
        STATE_RUN  = 1'b1
    } run_state_t;

    // which output lines get darkened
    typedef enum logic [1:0] {
        SCANLINE_OFF  = 2'd0,
        SCANLINE_EVEN = 2'd1,
        SCANLINE_ODD  = 2'd2
    } scanline_mode_t;

    // one frame-buffer word, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

endpackage

//--- project.f
+incdir+hdl
hdl/video_pkg.sv
hdl/beam_if.sv
hdl/beam_timing.sv
hdl/frame_reader.sv
hdl/scanline_shader.sv
hdl/video_output_top.sv
sim/fb_ram_model.sv
sim/tb_video_output.sv

//--- sim/fb_ram_model.sv
// Frame-buffer RAM model with one-cycle read latency, instantiated by the video testbench
`timescale 1ns/1ns

`include "video_defs.svh"

module fb_ram_model (
    input  logic                      clock,
    input  logic [`FB_ADDR_WIDTH-1:0] rdaddr,
    output logic [23:0]               rddata
);

    logic [23:0] mem [0:`FB_WORDS-1];

    // red is the address, green the address with a fixed mask, blue constant
    initial begin
        for (int addr = 0; addr < `FB_WORDS; addr++) begin
            mem[addr] = {8'(addr), 8'(addr) ^ 8'h5a, 8'hc3};
        end
    end

    // synchronous read, data one clock after the address
    always @(posedge clock) begin
        rddata <= mem[rdaddr];
    end

endmodule

//--- sim/tb_video_output.sv
// Directed testbench for the video output stage; compile with project.f, top is tb_video_output
`timescale 1ns/1ns

`include "video_defs.svh"

module tb_video_output;
    import video_pkg::*;

    localparam int frame_cycles   = `H_TOTAL * `V_TOTAL;
    localparam int first_pixel    = 4;
    localparam int settle_cycle   = first_pixel + `SETTLE_FRAMES * frame_cycles;
    localparam int timeout_cycles = 8 + 20 * frame_cycles;

    logic                      clock;
    logic                      reset;
    logic                      start;
    scanline_mode_t            scanline_mode;
    logic [7:0]                scanline_intensity;
    logic [`FB_ADDR_WIDTH-1:0] rdaddr;
    logic [23:0]               rddata;
    logic [23:0]               video_out;
    logic                      hsync;
    logic                      vsync;
    logic                      draw_area;
    logic                      settled;

    int     edge_count;
    int     start_edge;
    bit     started;
    int     check_count;
    int     error_count;
    integer seed;

    video_output_top u_video_output_top (
        .clock              (clock),
        .reset              (reset),
        .start              (start),
        .scanline_mode      (scanline_mode),
        .scanline_intensity (scanline_intensity),
        .rdaddr             (rdaddr),
        .rddata             (rddata),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area),
        .settled            (settled)
    );

    fb_ram_model u_fb_ram_model (
        .clock  (clock),
        .rdaddr (rdaddr),
        .rddata (rddata)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        edge_count = edge_count + 1;
    end

    initial begin
        wait (edge_count >= timeout_cycles);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("summary: %0d checks, %0d errors", check_count, error_count + 1);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // word the RAM holds at an address
    function automatic logic [23:0] stored_word(input int addr);
        logic [7:0] a;
        a = addr[7:0];
        return {a, a ^ 8'h5a, 8'hc3};
    endfunction

    // buffer word behind an output column and line
    function automatic int word_address(input int col, input int line);
        return (line / `LINE_REPEAT) * `FB_LINE_WORDS + col / `PIXEL_REPEAT;
    endfunction

    function automatic logic [7:0] dim(input logic [7:0] c, input logic [7:0] g);
        int product;
        product = c * g;
        return product / 256;
    endfunction

    function automatic logic [23:0] expected_video(input int col, input int line);
        logic [23:0] word;
        bit          darken;
        word   = stored_word(word_address(col, line));
        darken = (scanline_mode == SCANLINE_EVEN && line % 2 == 0)
              || (scanline_mode == SCANLINE_ODD && line % 2 == 1);
        if (darken) begin
            word = {dim(word[23:16], scanline_intensity),
                    dim(word[15:8], scanline_intensity),
                    dim(word[7:0], scanline_intensity)};
        end
        return word;
    endfunction

    // output column/line counter within the frame
    function automatic int frame_phase();
        return (edge_count - start_edge - first_pixel) % frame_cycles;
    endfunction

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [23:0] got,
                                 input logic [23:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_outputs();
        int          k;
        int          col;
        int          line;
        int          since_start;
        int          addr_pos;
        int          addr_col;
        int          addr_line;
        logic        exp_hsync;
        logic        exp_vsync;
        logic        exp_draw;
        logic [23:0] exp_video;
        logic [23:0] exp_addr;
        k           = edge_count - start_edge - first_pixel;
        since_start = edge_count - start_edge;
        if (!started || k < 0) begin
            exp_hsync = 1'b1;
            exp_vsync = 1'b1;
            exp_draw  = 1'b0;
            exp_video = '0;
        end else begin
            col       = k % `H_TOTAL;
            line      = (k / `H_TOTAL) % `V_TOTAL;
            // sync pulses are active low
            exp_hsync = !(col >= `H_SYNC_START && col < `H_SYNC_START + `H_SYNC_WIDTH);
            exp_vsync = !(line >= `V_SYNC_START && line < `V_SYNC_START + `V_SYNC_WIDTH);
            exp_draw  = (col < `H_VISIBLE) && (line < `V_VISIBLE);
            exp_video = exp_draw ? expected_video(col, line) : '0;
        end
        // read address is registered two cycles after start, one ahead of the RAM data
        addr_pos = since_start - 2;
        if (!started || addr_pos < 0) begin
            exp_addr = '0;
        end else begin
            addr_col  = addr_pos % `H_TOTAL;
            addr_line = (addr_pos / `H_TOTAL) % `V_TOTAL;
            if (addr_col < `H_VISIBLE && addr_line < `V_VISIBLE) begin
                exp_addr = word_address(addr_col, addr_line);
            end else begin
                exp_addr = '0;
            end
        end
        compare_value("hsync", hsync, exp_hsync);
        compare_value("vsync", vsync, exp_vsync);
        compare_value("draw_area", draw_area, exp_draw);
        compare_value("video_out", video_out, exp_video);
        compare_value("rdaddr", rdaddr, exp_addr);
        // settled may rise anywhere inside a small window around the 15th wrap
        if (!started || since_start < settle_cycle - 2) begin
            compare_value("settled", settled, 1'b0);
        end else if (since_start > settle_cycle + 2) begin
            compare_value("settled", settled, 1'b1);
        end
    endtask

    // stop on the last output cycle of a frame
    task automatic align_to_frame();
        while (frame_phase() != frame_cycles - 1) begin
            next_cycle();
            compare_outputs();
        end
    endtask

    task automatic run_frame();
        for (int i = 0; i < frame_cycles; i++) begin
            next_cycle();
            compare_outputs();
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic idle_after_reset();
        repeat (50) begin
            next_cycle();
            compare_outputs();
        end
    endtask

    task automatic start_latency();
        start      = 1'b1;
        start_edge = edge_count + 1;
        started    = 1'b1;
        next_cycle();
        start = 1'b0;
        compare_outputs();
        while (draw_area !== 1'b1 && edge_count - start_edge < 20) begin
            next_cycle();
            compare_outputs();
        end
        if (draw_area !== 1'b1) begin
            error_count++;
            $display("draw area never rose after the start strobe");
        end else begin
            compare_value("draw_area rise latency", edge_count - start_edge, first_pixel);
        end
    endtask

    task automatic sync_timing();
        int hsync_low;
        int vsync_low;
        hsync_low     = 0;
        vsync_low     = 0;
        scanline_mode = SCANLINE_OFF;
        align_to_frame();
        for (int i = 0; i < frame_cycles; i++) begin
            next_cycle();
            // second strobe mid-frame is ignored while running
            start = (i == frame_cycles / 2);
            compare_outputs();
            if (hsync === 1'b0) begin
                hsync_low++;
            end
            if (vsync === 1'b0) begin
                vsync_low++;
            end
        end
        compare_value("hsync low cycles", hsync_low, `V_TOTAL * `H_SYNC_WIDTH);
        compare_value("vsync low cycles", vsync_low, `V_SYNC_WIDTH * `H_TOTAL);
    endtask

    task automatic pixel_repeat();
        scanline_mode = SCANLINE_OFF;
        align_to_frame();
        run_frame();
    endtask

    task automatic scanline_darkening(input scanline_mode_t mode);
        scanline_mode      = mode;
        scanline_intensity = $random(seed);
        align_to_frame();
        run_frame();
    endtask

    task automatic settled_flag();
        int rise;
        scanline_mode = SCANLINE_OFF;
        while (settled !== 1'b1 && edge_count - start_edge < settle_cycle + frame_cycles) begin
            next_cycle();
            compare_outputs();
        end
        if (settled !== 1'b1) begin
            error_count++;
            $display("settled never rose within %0d frames of the start", `SETTLE_FRAMES + 1);
        end else begin
            rise = edge_count - start_edge;
            check_count++;
            if (rise < settle_cycle - 2 || rise > settle_cycle + 2) begin
                error_count++;
                $display("CHECK FAILED at %0t ns: settled rise cycle expected %0d, got %0d",
                         $time, settle_cycle, rise);
            end
        end
        // must stay high from here on
        align_to_frame();
        run_frame();
    endtask

    initial begin
        clock              = 1'b0;
        reset              = 1'b1;
        start              = 1'b0;
        scanline_mode      = SCANLINE_OFF;
        scanline_intensity = 8'h00;
        edge_count         = 0;
        start_edge         = 0;
        started            = 1'b0;
        check_count        = 0;
        error_count        = 0;
        seed               = 32'ha703;

        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        idle_after_reset();
        start_latency();
        sync_timing();
        pixel_repeat();
        scanline_darkening(SCANLINE_EVEN);
        scanline_darkening(SCANLINE_ODD);
        settled_flag();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
